// ==== common/Types.sv ====
package Types;

    // ------------------------------
    // Data memory geometry
    // ------------------------------

    localparam int DATA_ADDR_BITS = 12;                   // Byte address width, 4 KiB
    localparam int DATA_MEM_BYTES = 2 ** DATA_ADDR_BITS;  // Total bytes in data memory

    // ------------------------------
    // Basic words
    // ------------------------------

    typedef logic [31:0] Data;                  // Register and memory data word
    typedef logic [31:0] InstAddr;              // Instruction address
    typedef logic [DATA_ADDR_BITS-1:0] DataAddr; // Data memory byte address
    typedef logic [4:0] RegIndex;               // Destination register number

    // ------------------------------
    // Control codes
    // ------------------------------

    // Memory access size
    typedef enum logic [1:0] {
        DataAccess_Byte = 2'b00,    // 8 bit
        DataAccess_Half = 2'b01,    // 16 bit, even address
        DataAccess_Word = 2'b10     // 32 bit, address multiple of 4
    } DataAccess;

    // Write-back source
    //   Alu : result from execute
    //   Mem : extended load data
    //   Pc4 : return address for jumps
    typedef enum logic [1:0] {
        WbSel_Alu = 2'b00,
        WbSel_Mem = 2'b01,
        WbSel_Pc4 = 2'b10
    } WbSel;

endpackage

// ==== memory/DataMemory.sv ====
module DataMemory
    import Types::*;
(
    input  logic      i_clock,      // System clock
    input  DataAddr   i_addr,       // Byte address
    input  DataAccess i_access,     // Access size
    input  logic      i_wrEnable,   // Store strobe, already qualified by valid
    input  Data       i_wrData,     // Store data in the low bytes

    output Data       o_rdData,     // Addressed bytes shifted down to bit 0
    output logic      o_misaligned);// Access crosses its natural boundary

    // ------------------------------
    // Storage
    // ------------------------------

    // Four byte lanes, one per byte of a word, little-endian
    // Lane 0 holds the byte at the word address itself
    logic [7:0] lane0 [DATA_MEM_BYTES/4];
    logic [7:0] lane1 [DATA_MEM_BYTES/4];
    logic [7:0] lane2 [DATA_MEM_BYTES/4];
    logic [7:0] lane3 [DATA_MEM_BYTES/4];

    // ------------------------------
    // Address split
    // ------------------------------

    logic [DATA_ADDR_BITS-3:0] wordIndex;   // Row shared by all lanes
    logic [1:0]                laneOffset;  // First lane touched

    assign wordIndex  = i_addr[DATA_ADDR_BITS-1:2];
    assign laneOffset = i_addr[1:0];

    // ------------------------------
    // Alignment check
    // ------------------------------

    always_comb begin
        unique case (i_access)
            DataAccess_Half: o_misaligned = i_addr[0];     // Odd half address
            DataAccess_Word: o_misaligned = |i_addr[1:0];  // Not a multiple of 4
            default:         o_misaligned = 1'b0;          // Bytes always fit
        endcase
    end

    // ------------------------------
    // Store lane placement
    // ------------------------------

    logic [3:0] sizeMask;   // Lanes for the size, before offset
    logic [3:0] laneMask;   // Lanes actually written
    Data        laneData;   // Store data moved onto its lanes
    logic       wrAllowed;  // Store passes the alignment check

    always_comb begin
        unique case (i_access)
            DataAccess_Byte: sizeMask = 4'b0001;
            DataAccess_Half: sizeMask = 4'b0011;
            DataAccess_Word: sizeMask = 4'b1111;
            default:         sizeMask = 4'b0000;  // Unknown size writes nothing
        endcase
    end

    assign laneMask  = sizeMask << laneOffset;             // Aligned, so never wraps
    assign laneData  = i_wrData << {laneOffset, 3'b000};   // Byte offset times 8
    assign wrAllowed = i_wrEnable & ~o_misaligned;         // Misaligned store dropped

    always_ff @(posedge i_clock) begin
        if (wrAllowed) begin
            if (laneMask[0])
                lane0[wordIndex] <= laneData[7:0];
            if (laneMask[1])
                lane1[wordIndex] <= laneData[15:8];
            if (laneMask[2])
                lane2[wordIndex] <= laneData[23:16];
            if (laneMask[3])
                lane3[wordIndex] <= laneData[31:24];
        end
    end

    // ------------------------------
    // Read alignment
    // ------------------------------

    Data rdWord;  // Whole addressed word

    // Asynchronous read, sees all stores of earlier cycles
    assign rdWord = {lane3[wordIndex], lane2[wordIndex], lane1[wordIndex], lane0[wordIndex]};

    // Addressed byte lands at bit 0, upper bytes are don't care for the stage
    assign o_rdData = rdWord >> {laneOffset, 3'b000};

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MemorySubsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG="Test FAILED"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module MemorySubsystemTb -f src.f -Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Error limit raised so the testbench sees the failed flag first
"./$BUILD_DIR/simv" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== source/MemorySubsystem.sv ====
module MemorySubsystem
    import Types::*;
(
    input  logic      i_clock,          // System clock
    input  logic      i_reset,          // Synchronous reset, active high

    // Slot from execute
    input  logic      i_valid,
    input  InstAddr   i_pc,
    input  Data       i_result,         // ALU result or address
    input  Data       i_dataB,          // Store data
    input  logic      i_memWrEnable,
    input  DataAccess i_memAccess,
    input  logic      i_memUnsigned,
    input  WbSel      i_regWrDataSel,
    input  RegIndex   i_rd,
    input  logic      i_regWrEnable,

    // Slot leaving MEM/WB
    output logic      o_wbValid,
    output RegIndex   o_wbRd,
    output logic      o_wbRegWrEnable,
    output Data       o_wbData,
    output logic      o_wbFault);

    // ------------------------------
    // Internal wires
    // ------------------------------

    DataAddr   memAddr;        // Stage to memory
    DataAccess memAccess;
    logic      memWrEnable;
    Data       memWrData;
    Data       memRdData;      // Memory to stage
    logic      memMisaligned;  // Memory to write-back
    Data       regWrData;      // Stage to write-back

    StageMEM stage (
        .i_pc           (i_pc),
        .i_result       (i_result),
        .i_dataB        (i_dataB),
        .i_valid        (i_valid),
        .i_memWrEnable  (i_memWrEnable),
        .i_memAccess    (i_memAccess),
        .i_memUnsigned  (i_memUnsigned),
        .i_regWrDataSel (i_regWrDataSel),
        .i_memRdData    (memRdData),
        .o_memAddr      (memAddr),
        .o_memAccess    (memAccess),
        .o_memWrEnable  (memWrEnable),
        .o_memWrData    (memWrData),
        .o_regWrData    (regWrData));

    DataMemory dataMem (
        .i_clock      (i_clock),
        .i_addr       (memAddr),
        .i_access     (memAccess),
        .i_wrEnable   (memWrEnable),
        .i_wrData     (memWrData),
        .o_rdData     (memRdData),
        .o_misaligned (memMisaligned));

    // Valid, rd and write enable bypass the stage
    WritebackRegister wbReg (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_rd          (i_rd),
        .i_regWrEnable (i_regWrEnable),
        .i_data        (regWrData),
        .i_fault       (memMisaligned),
        .o_valid       (o_wbValid),
        .o_rd          (o_wbRd),
        .o_regWrEnable (o_wbRegWrEnable),
        .o_data        (o_wbData),
        .o_fault       (o_wbFault));

endmodule

// ==== source/StageMEM.sv ====
module StageMEM
    import Types::*;
(
    input  InstAddr   i_pc,             // Address of the instruction in this slot
    input  Data       i_result,         // ALU result, also the memory address
    input  Data       i_dataB,          // rs2 value, store data
    input  logic      i_valid,          // Slot carries a real instruction

    input  logic      i_memWrEnable,    // Store request
    input  DataAccess i_memAccess,      // Access size
    input  logic      i_memUnsigned,    // Zero-extend loads

    input  WbSel      i_regWrDataSel,   // Write-back source
    input  Data       i_memRdData,      // Read data from memory, aligned to bit 0

    output DataAddr   o_memAddr,        // Byte address to memory
    output DataAccess o_memAccess,      // Access size to memory
    output logic      o_memWrEnable,    // Qualified write strobe
    output Data       o_memWrData,      // Store data, low bytes used
    output Data       o_regWrData);     // Value for the destination register

    // ------------------------------
    // Data memory bus
    // ------------------------------

    // Address is the low part of the ALU result
    assign o_memAddr     = i_result[DATA_ADDR_BITS-1:0];
    assign o_memAccess   = i_memAccess;
    assign o_memWrEnable = i_memWrEnable & i_valid;  // Bubbles never store
    assign o_memWrData   = i_dataB;                  // Memory picks its own lanes

    // ------------------------------
    // Load extension
    // ------------------------------

    Data loadData;  // Extended load value

    always_comb begin
        unique case ({i_memUnsigned, i_memAccess})
            // Signed byte, replicate bit 7
            {1'b0, DataAccess_Byte}:
                loadData = {{24{i_memRdData[7]}}, i_memRdData[7:0]};

            // Signed half, replicate bit 15
            {1'b0, DataAccess_Half}:
                loadData = {{16{i_memRdData[15]}}, i_memRdData[15:0]};

            {1'b1, DataAccess_Byte}:
                loadData = {24'h000000, i_memRdData[7:0]};   // Unsigned byte

            {1'b1, DataAccess_Half}:
                loadData = {16'h0000, i_memRdData[15:0]};    // Unsigned half

            // Word, sign flag has no effect
            default:
                loadData = i_memRdData;
        endcase
    end

    // ------------------------------
    // Return address
    // ------------------------------

    InstAddr pcPlus4;  // Link value for JAL and JALR

    assign pcPlus4 = i_pc + InstAddr'(4);

    // ------------------------------
    // Write-back selection
    // ------------------------------

    // Unused code falls back to the ALU result
    always_comb begin
        unique case (i_regWrDataSel)
            WbSel_Alu: o_regWrData = i_result;  // Arithmetic and logic ops
            WbSel_Mem: o_regWrData = loadData;  // Loads
            WbSel_Pc4: o_regWrData = pcPlus4;   // Jumps
            default:   o_regWrData = i_result;
        endcase
    end

endmodule

// ==== source/WritebackRegister.sv ====
module WritebackRegister
    import Types::*;
(
    input  logic    i_clock,        // System clock
    input  logic    i_reset,        // Synchronous reset, active high

    input  logic    i_valid,        // Slot valid from MEM
    input  RegIndex i_rd,           // Destination register
    input  logic    i_regWrEnable,  // Instruction writes a register
    input  Data     i_data,         // Write-back value
    input  logic    i_fault,        // Misaligned access in this slot

    output logic    o_valid,        // Slot valid in WB
    output RegIndex o_rd,
    output logic    o_regWrEnable,  // Never high on a fault or bubble
    output Data     o_data,
    output logic    o_fault);       // Fault flag, only on valid slots

    // ------------------------------
    // Control bits
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid       <= 1'b0;
            o_regWrEnable <= 1'b0;
            o_fault       <= 1'b0;
        end
        else begin
            o_valid       <= i_valid;
            o_regWrEnable <= i_valid & i_regWrEnable & ~i_fault;  // Faulting load is dropped
            o_fault       <= i_valid & i_fault;                   // Bubbles cannot fault
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------

    // Meaningful only while o_valid is high
    always_ff @(posedge i_clock) begin
        o_rd   <= i_rd;
        o_data <= i_data;
    end

endmodule

// ==== src.f ====
common/Types.sv
source/StageMEM.sv
memory/DataMemory.sv
source/WritebackRegister.sv
source/MemorySubsystem.sv
verif/ClockGen.sv
verif/MemorySubsystem_properties.sv
verif/MemorySubsystemTb.sv

// ==== verif/ClockGen.sv ====
module ClockGen (
    output logic o_clock,   // Free running testbench clock
    output logic o_reset);  // Synchronous reset, active high

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 2;   // 4 ns period
    localparam int RESET_CYCLES = 10;

    initial begin
        o_clock = 1'b0;
        forever #HALF_PERIOD o_clock = ~o_clock;
    end

    // Reset drops right after the tenth rising edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_reset <= 1'b0;
    end

endmodule

// ==== verif/MemorySubsystemTb.sv ====
module MemorySubsystemTb
    import Types::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRIVE_DELAY  = 1;       // ns after the rising edge
    localparam int RESET_LIMIT  = 100;     // Cycles
    localparam int DRAIN_LIMIT  = 20;      // Cycles
    localparam int RUN_LIMIT_NS = 40000;
    localparam int WINDOW_BASE  = 'h100;   // Byte window used by the stimulus
    localparam int WINDOW_BYTES = 128;
    localparam int RANDOM_OPS   = 400;

    logic      clock;
    logic      reset;
    logic      valid;
    InstAddr   pc;
    Data       result;
    Data       dataB;
    logic      memWrEnable;
    DataAccess memAccess;
    logic      memUnsigned;
    WbSel      regWrDataSel;
    RegIndex   rd;
    logic      regWrEnable;
    logic      wbValid;
    RegIndex   wbRd;
    logic      wbRegWrEnable;
    Data       wbData;
    logic      wbFault;
    integer    seed = 34855;

    ClockGen clockGen (.o_clock(clock), .o_reset(reset));

    MemorySubsystem UUT (
        .i_clock         (clock),
        .i_reset         (reset),
        .i_valid         (valid),
        .i_pc            (pc),
        .i_result        (result),
        .i_dataB         (dataB),
        .i_memWrEnable   (memWrEnable),
        .i_memAccess     (memAccess),
        .i_memUnsigned   (memUnsigned),
        .i_regWrDataSel  (regWrDataSel),
        .i_rd            (rd),
        .i_regWrEnable   (regWrEnable),
        .o_wbValid       (wbValid),
        .o_wbRd          (wbRd),
        .o_wbRegWrEnable (wbRegWrEnable),
        .o_wbData        (wbData),
        .o_wbFault       (wbFault));

    bind MemorySubsystem MemorySubsystem_properties props (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_valid         (i_valid),
        .i_pc            (i_pc),
        .i_result        (i_result),
        .i_dataB         (i_dataB),
        .i_memWrEnable   (i_memWrEnable),
        .i_memAccess     (i_memAccess),
        .i_memUnsigned   (i_memUnsigned),
        .i_regWrDataSel  (i_regWrDataSel),
        .i_rd            (i_rd),
        .i_regWrEnable   (i_regWrEnable),
        .i_wbValid       (o_wbValid),
        .i_wbRd          (o_wbRd),
        .i_wbRegWrEnable (o_wbRegWrEnable),
        .i_wbData        (o_wbData),
        .i_wbFault       (o_wbFault));

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic Data rnd();
        return $random(seed);
    endfunction

    function automatic DataAddr windowAddr(input int offset);
        return DataAddr'(WINDOW_BASE + offset);
    endfunction

    // Random upper bits, the memory only decodes the low ones
    function automatic Data addressWord(input DataAddr a);
        Data r;
        r = rnd();
        return {r[31:DATA_ADDR_BITS], a};
    endfunction

    task automatic reportTimeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped after a timeout");
    endtask

    // Presents one slot and moves to the next drive point
    task automatic issue(input logic v, input Data res, input Data db, input logic wr,
                         input DataAccess acc, input logic uns, input WbSel sel,
                         input logic regWr);
        Data r;
        r = rnd();
        valid        = v;
        pc           = rnd();
        result       = res;
        dataB        = db;
        memWrEnable  = wr;
        memAccess    = acc;
        memUnsigned  = uns;
        regWrDataSel = sel;
        rd           = RegIndex'(r);
        regWrEnable  = regWr;
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic store(input DataAddr a, input DataAccess acc, input Data d);
        issue(1'b1, addressWord(a), d, 1'b1, acc, 1'b0, WbSel_Alu, 1'b0);
    endtask

    task automatic load(input DataAddr a, input DataAccess acc, input logic uns);
        issue(1'b1, addressWord(a), rnd(), 1'b0, acc, uns, WbSel_Mem, 1'b1);
    endtask

    task automatic bubble();
        issue(1'b0, rnd(), rnd(), 1'b1, DataAccess_Word, 1'b0, WbSel_Mem, 1'b1);  // Junk must not act
    endtask

    function automatic DataAccess pickAccess(input Data r);
        if (r % 3 == 0)
            return DataAccess_Byte;
        else if (r % 3 == 1)
            return DataAccess_Half;
        else
            return DataAccess_Word;
    endfunction

    task automatic randomOp();
        int kind;
        int off;
        DataAccess acc;
        Data r;
        kind = rnd() % 6;
        off  = rnd() % WINDOW_BYTES;
        acc  = pickAccess(rnd());
        r    = rnd();
        if (r[1:0] != 2'b00)
            off = off & ~3;  // Mostly aligned
        case (kind)
            0:       store(windowAddr(off), acc, rnd());
            1, 2:    load(windowAddr(off), acc, r[2]);
            3:       issue(1'b1, rnd(), rnd(), 1'b0, DataAccess_Byte, 1'b0, WbSel_Alu, 1'b1);
            4:       issue(1'b1, rnd(), rnd(), 1'b0, DataAccess_Byte, 1'b0, WbSel_Pc4, 1'b1);
            default: bubble();
        endcase
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    // First failed assertion ends the run
    always @(posedge clock) begin
        if (UUT.props.failed) begin
            $display("Test FAILED");
            $fatal(1, "Stopped at the first failed check");
        end
    end

    initial begin
        #RUN_LIMIT_NS;
        reportTimeout("the end of the stimulus");
    end

    initial begin
        Data d;
        int waited;
        valid        = 1'b0;
        pc           = '0;
        result       = '0;
        dataB        = '0;
        memWrEnable  = 1'b0;
        memAccess    = DataAccess_Byte;
        memUnsigned  = 1'b0;
        regWrDataSel = WbSel_Alu;
        rd           = '0;
        regWrEnable  = 1'b0;

        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > RESET_LIMIT)
                reportTimeout("reset to be released");
        end while (reset);
        #DRIVE_DELAY;

        repeat (3) bubble();
        for (int off = 0; off < WINDOW_BYTES; off += 4)
            store(windowAddr(off), DataAccess_Word, rnd());  // Fill the window
        for (int off = 0; off < WINDOW_BYTES; off += 4)
            load(windowAddr(off), DataAccess_Word, 1'b0);

        // Each lane, both extensions, then the whole word
        for (int off = 0; off < 4; off++) begin
            d = rnd();
            d[7] = off[0];
            store(windowAddr(off), DataAccess_Byte, d);
            load(windowAddr(off), DataAccess_Byte, 1'b0);
            load(windowAddr(off), DataAccess_Byte, 1'b1);
            load(windowAddr(0), DataAccess_Word, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            d = rnd();
            d[15] = off[1];
            store(windowAddr(off), DataAccess_Half, d);
            load(windowAddr(off), DataAccess_Half, 1'b0);
            load(windowAddr(off), DataAccess_Half, 1'b1);
            load(windowAddr(0), DataAccess_Word, 1'b0);
        end

        // Misaligned stores must leave the words intact
        store(windowAddr(5), DataAccess_Word, rnd());
        store(windowAddr(7), DataAccess_Half, rnd());
        load(windowAddr(4), DataAccess_Word, 1'b0);
        load(windowAddr(3), DataAccess_Half, 1'b0);
        load(windowAddr(6), DataAccess_Word, 1'b1);
        issue(1'b1, rnd(), rnd(), 1'b0, DataAccess_Byte, 1'b0, WbSel_Alu, 1'b1);
        issue(1'b1, rnd(), rnd(), 1'b0, DataAccess_Byte, 1'b0, WbSel_Pc4, 1'b1);

        for (int n = 0; n < RANDOM_OPS; n++)
            randomOp();

        // Drain until the last slot has left
        waited = 0;
        bubble();
        while (wbValid) begin
            bubble();
            waited++;
            if (waited > DRAIN_LIMIT)
                reportTimeout("the pipeline to empty");
        end
        bubble();

        if (UUT.props.failed) begin
            $display("Test FAILED");
            $fatal(1, "A check failed near the end of the run");
        end
        else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== verif/MemorySubsystem_properties.sv ====
module MemorySubsystem_properties
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_valid,          // Slot presented to MEM
    input  InstAddr   i_pc,
    input  Data       i_result,
    input  Data       i_dataB,
    input  logic      i_memWrEnable,
    input  DataAccess i_memAccess,
    input  logic      i_memUnsigned,
    input  WbSel      i_regWrDataSel,
    input  RegIndex   i_rd,
    input  logic      i_regWrEnable,
    input  logic      i_wbValid,        // Slot leaving MEM/WB
    input  RegIndex   i_wbRd,
    input  logic      i_wbRegWrEnable,
    input  Data       i_wbData,
    input  logic      i_wbFault);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] shadow [DATA_MEM_BYTES];  // Reference copy of data memory
    logic       failed = 1'b0;            // Polled by the testbench

    // ------------------------------
    // Expected values of this slot
    // ------------------------------

    DataAddr    addr;
    logic [2:0] sizeBytes;   // 1, 2 or 4
    logic       misaligned;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    Data        loadExp;

    assign addr       = i_result[DATA_ADDR_BITS-1:0];
    assign sizeBytes  = 3'd1 << i_memAccess;
    assign misaligned = (addr[1:0] & (sizeBytes[1:0] - 2'd1)) != 2'd0;  // Address mod size
    assign b0 = shadow[addr];
    assign b1 = shadow[addr + DataAddr'(1)];
    assign b2 = shadow[addr + DataAddr'(2)];
    assign b3 = shadow[addr + DataAddr'(3)];

    always_comb begin
        if (i_memAccess == DataAccess_Byte)
            loadExp = i_memUnsigned ? {24'h000000, b0} : {{24{b0[7]}}, b0};
        else if (i_memAccess == DataAccess_Half)
            loadExp = i_memUnsigned ? {16'h0000, b1, b0} : {{16{b1[7]}}, b1, b0};
        else
            loadExp = {b3, b2, b1, b0};  // Little-endian word
    end

    // ------------------------------
    // One cycle delayed copies
    // ------------------------------

    logic    expValid;
    logic    expFault;
    logic    expWrEn;
    logic    chkLoad;  // Aligned load in WB
    logic    chkSel;   // ALU or PC+4 result in WB
    Data     expData;
    RegIndex expRd;    // Destination carried with the slot

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            expValid <= 1'b0;
            expFault <= 1'b0;
            expWrEn  <= 1'b0;
            chkLoad  <= 1'b0;
            chkSel   <= 1'b0;
        end
        else begin
            expValid <= i_valid;
            expFault <= i_valid & misaligned;
            expWrEn  <= i_valid & i_regWrEnable & ~misaligned;
            chkLoad  <= i_valid & (i_regWrDataSel == WbSel_Mem) & ~misaligned;
            chkSel   <= i_valid & (i_regWrDataSel != WbSel_Mem);
        end
        expRd <= i_rd;
        case (i_regWrDataSel)
            WbSel_Mem: expData <= loadExp;
            WbSel_Pc4: expData <= i_pc + 32'd4;
            default:   expData <= i_result;
        endcase
        // Shadow follows valid aligned stores only
        if (i_valid & i_memWrEnable & ~misaligned) begin
            shadow[addr] <= i_dataB[7:0];
            if (i_memAccess != DataAccess_Byte)
                shadow[addr + DataAddr'(1)] <= i_dataB[15:8];
            if (i_memAccess == DataAccess_Word) begin
                shadow[addr + DataAddr'(2)] <= i_dataB[23:16];
                shadow[addr + DataAddr'(3)] <= i_dataB[31:24];
            end
        end
    end

    // ------------------------------
    // Checks, half a cycle after capture
    // ------------------------------

    a_wbValid: assert property (@(negedge i_clock) i_wbValid == expValid)
        else begin
            failed = 1'b1;
            $error("[ERROR] %0t o_wbValid expected %b actual %b", $time, expValid, i_wbValid);
        end

    a_bubbleNoWrite: assert property (@(negedge i_clock) !i_wbValid |-> !i_wbRegWrEnable)
        else begin
            failed = 1'b1;
            $error("[ERROR] %0t o_wbRegWrEnable expected 0 actual %b", $time, i_wbRegWrEnable);
        end

    a_bubbleNoFault: assert property (@(negedge i_clock) !i_wbValid |-> !i_wbFault)
        else begin
            failed = 1'b1;
            $error("[ERROR] %0t o_wbFault expected 0 actual %b", $time, i_wbFault);
        end

    a_wbFault: assert property (@(negedge i_clock) i_wbValid |-> i_wbFault == expFault)
        else begin
            failed = 1'b1;
            $error("[ERROR] %0t o_wbFault expected %b actual %b", $time, expFault, i_wbFault);
        end

    a_wbRegWrEnable: assert property (@(negedge i_clock)
        i_wbValid |-> i_wbRegWrEnable == expWrEn)
        else begin
            failed = 1'b1;
            $error("[ERROR] %0t o_wbRegWrEnable expected %b actual %b",
                $time, expWrEn, i_wbRegWrEnable);
        end

    a_wbRd: assert property (@(negedge i_clock) i_wbValid |-> i_wbRd == expRd)
        else begin
            failed = 1'b1;
            $error("[ERROR] %0t o_wbRd expected %0d actual %0d", $time, expRd, i_wbRd);
        end

    a_loadData: assert property (@(negedge i_clock) chkLoad |-> i_wbData == expData)
        else begin
            failed = 1'b1;
            $error("[ERROR] %0t o_wbData expected %h actual %h", $time, expData, i_wbData);
        end

    a_selectData: assert property (@(negedge i_clock) chkSel |-> i_wbData == expData)
        else begin
            failed = 1'b1;
            $error("[ERROR] %0t o_wbData expected %h actual %h", $time, expData, i_wbData);
        end

endmodule
